// File: verilog.f
common/memTilePkg.sv
design/memWrap/dMem.sv
design/memWrap/crMem.sv
design/memWrap/memWrap.sv
design/fabricReqFifo.sv
design/memTile.sv
tests/memTile_sva.sv
tests/memTileTb.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := memTileTb
FILELIST  := verilog.f
OBJDIR    := obj_dir
LOG       := sim.log

SRCS := $(shell grep -v '^+' $(FILELIST))
SIM  := $(OBJDIR)/V$(TOP)

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
$(SIM): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

run: $(SIM)
	./$(SIM) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "^Testbench passed$$" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)

// File: tests/memTileTb.sv
// Testbench for the tile memory subsystem
// Stimulus table, fabric sender model with credits, response checks
`timescale 1ns/100ps

module memTileTb import memTilePkg::*; ();

   localparam int FifoDepth   = 4;
   localparam int DMemWords   = 256;
   localparam int WaitLimit   = 200;
   // Row kinds
   localparam int PortCore    = 0;
   localparam int PortFabric  = 1;
   localparam int PortClash   = 2;
   localparam int PortLeds    = 3;

   typedef struct {
      int     port;
      tOpcode op;
      tAddr   addr;
      tData   data;
      tByteEn be;
      tData   exp;
      int     test;
   } tRow;

   logic   Clk;
   logic   arstN;
   tTileId localTileId;
   tAddr   dMemAddrQ103H;
   tData   dMemWrDataQ103H;
   tByteEn dMemByteEnQ103H;
   logic   dMemWrEnQ103H;
   logic   dMemRdEnQ103H;
   tData   dMemRdRspQ104H;
   logic   fabricReqValid;
   tOpcode fabricReqOpcode;
   tAddr   fabricReqAddr;
   tData   fabricReqData;
   tTileId fabricReqRequestorId;
   logic   fabricCredit;
   logic   fabricRspValid;
   tAddr   fabricRspAddr;
   tData   fabricRspData;
   tData   switches;
   tData   leds;

   // Sender state and scoreboard
   tRow         rows[$];
   logic [63:0] expQ[$];
   logic [1:0]  creditHist = 2'b00;
   tTileId      reqId = 8'h40;
   int          credits = 0;
   int          errCount = 0;
   int          checkCount = 0;
   int          readsSent = 0;
   int          rspCount = 0;
   bit          timedOut = 1'b0;
   string       testNames [6] = '{"core word access", "sub-word access", "control registers",
                                  "fabric access", "fabric burst", "same-cycle writes"};

   memTile #(
      .FifoDepth (FifoDepth),
      .DMemWords (DMemWords)
   ) dut (
      .Clk                  (Clk),
      .arstN                (arstN),
      .localTileId          (localTileId),
      .dMemAddrQ103H        (dMemAddrQ103H),
      .dMemWrDataQ103H      (dMemWrDataQ103H),
      .dMemByteEnQ103H      (dMemByteEnQ103H),
      .dMemWrEnQ103H        (dMemWrEnQ103H),
      .dMemRdEnQ103H        (dMemRdEnQ103H),
      .dMemRdRspQ104H       (dMemRdRspQ104H),
      .fabricReqValid       (fabricReqValid),
      .fabricReqOpcode      (fabricReqOpcode),
      .fabricReqAddr        (fabricReqAddr),
      .fabricReqData        (fabricReqData),
      .fabricReqRequestorId (fabricReqRequestorId),
      .fabricCredit         (fabricCredit),
      .fabricRspValid       (fabricRspValid),
      .fabricRspAddr        (fabricRspAddr),
      .fabricRspData        (fabricRspData),
      .switches             (switches),
      .leds                 (leds)
   );

   // 10 ns clock
   initial begin
      Clk = 1'b0;
      forever #5 Clk = ~Clk;
   end

   // ======================================================================
   // Helpers
   // ======================================================================
   task automatic checkValue(input string name, input tData exp, input tData act);
      checkCount++;
      if (exp !== act) begin
         $display("[ERROR] %0t %s expected %h actual %h", $time, name, exp, act);
         errCount++;
      end
   endtask

   task automatic noteTimeout(input string what);
      $display("Timeout, %s", what);
      timedOut = 1'b1;
   endtask

   function automatic void addRow(input int port, input tOpcode op, input tAddr addr,
                                  input tData data, input tByteEn be, input tData exp,
                                  input int test);
      rows.push_back('{port, op, addr, data, be, exp, test});
   endfunction

   // Word address inside the CR region
   function automatic tAddr crAddr(input tCrOffset off);
      crAddr = {CrRegionFloor, off, 2'b00};
   endfunction

   // One core access, read data checked at Q104H
   task automatic coreAccess(input tRow r);
      @(posedge Clk);
      dMemAddrQ103H   <= r.addr;
      dMemWrDataQ103H <= r.data;
      dMemByteEnQ103H <= r.be;
      dMemWrEnQ103H   <= (r.op == OpWr);
      dMemRdEnQ103H   <= (r.op == OpRd);
      @(posedge Clk);
      dMemWrEnQ103H   <= 1'b0;
      dMemRdEnQ103H   <= 1'b0;
      if (r.op == OpRd) begin
         @(negedge Clk);
         checkValue("dMemRdRspQ104H", r.exp, dMemRdRspQ104H);
      end
   endtask

   // Fabric sender, one request per call, needs a credit
   task automatic sendFabric(input tOpcode op, input tAddr addr, input tData data,
                             input tData exp);
      int waitCycles;
      waitCycles = 0;
      if (credits == 0) begin
         @(posedge Clk);
         fabricReqValid <= 1'b0;
      end
      while (credits == 0 && waitCycles < WaitLimit) begin
         @(negedge Clk);
         waitCycles++;
      end
      if (credits == 0) begin
         noteTimeout("no fabric credit came back");
      end else begin
         @(posedge Clk);
         fabricReqValid       <= 1'b1;
         fabricReqOpcode      <= op;
         fabricReqAddr        <= addr;
         fabricReqData        <= data;
         fabricReqRequestorId <= reqId;
         credits--;
         if (op == OpRd) begin
            expQ.push_back({reqId, addr[23:0], exp});
            readsSent++;
         end
         reqId++;
      end
   endtask

   // Stop sending, then wait for all credits and responses
   task automatic drainFabric();
      int waitCycles;
      @(posedge Clk);
      fabricReqValid <= 1'b0;
      waitCycles = 0;
      while ((credits != FifoDepth || expQ.size() != 0) && waitCycles < WaitLimit) begin
         @(negedge Clk);
         waitCycles++;
      end
      if (credits != FifoDepth || expQ.size() != 0) begin
         noteTimeout("fabric traffic did not drain");
      end
   endtask

   // Fabric write popped on the same edge as the core write
   task automatic clashWrite(input tAddr addr, input tData data);
      sendFabric(OpWr, addr, ~data, '0);
      @(posedge Clk);
      fabricReqValid  <= 1'b0;
      dMemAddrQ103H   <= addr;
      dMemWrDataQ103H <= data;
      dMemByteEnQ103H <= 4'hF;
      dMemWrEnQ103H   <= 1'b1;
      @(posedge Clk);
      dMemWrEnQ103H   <= 1'b0;
   endtask

   // ======================================================================
   // Credit return and response scoreboard
   // ======================================================================
   always @(posedge Clk) begin
      if (arstN && fabricCredit) begin
         credits++;
      end
   end

   always @(posedge Clk) begin
      logic [63:0] expRsp;
      if (arstN && fabricRspValid) begin
         // Pop two cycles back
         checkValue("fabricRspValid delay", 32'd1, tData'(creditHist[1]));
         if (expQ.size() == 0) begin
            $display("Fabric response at %0t with no read outstanding", $time);
            errCount++;
         end else begin
            expRsp = expQ.pop_front();
            checkValue("fabricRspAddr", expRsp[63:32], fabricRspAddr);
            checkValue("fabricRspData", expRsp[31:0], fabricRspData);
         end
         rspCount++;
      end
      creditHist <= {creditHist[0], fabricCredit};
   end

   // ======================================================================
   // Table build and run
   // ======================================================================
   initial begin
      tRow  r;
      int   testStartErr;
      bit   lastOfTest;
      tData d0, d1, b0, x1, h2, x3, w2, sw, led, s0, s1, f0, f1, clash;
      void'($urandom(32'h27c3_adbf));
      d0 = $urandom;
      d1 = $urandom;
      b0 = $urandom;
      x1 = $urandom;
      h2 = $urandom;
      x3 = $urandom;
      sw = $urandom;
      led = $urandom;
      s0 = $urandom;
      s1 = $urandom;
      f0 = $urandom;
      f1 = $urandom;
      clash = $urandom;
      // Inputs idle, reset held
      arstN = 1'b0;
      localTileId = 8'h05;
      dMemAddrQ103H = '0;
      dMemWrDataQ103H = '0;
      dMemByteEnQ103H = '0;
      dMemWrEnQ103H = 1'b0;
      dMemRdEnQ103H = 1'b0;
      fabricReqValid = 1'b0;
      fabricReqOpcode = OpRd;
      fabricReqAddr = '0;
      fabricReqData = '0;
      fabricReqRequestorId = '0;
      switches = sw;

      // Core word write and read back
      addRow(PortCore, OpWr, 32'h0001_0010, d0, 4'hF, '0, 0);
      addRow(PortCore, OpWr, 32'h0001_0014, d1, 4'hF, '0, 0);
      addRow(PortCore, OpRd, 32'h0001_0010, '0, 4'hF, d0, 0);
      addRow(PortCore, OpRd, 32'h0001_0014, '0, 4'hF, d1, 0);
      // Byte at 1, half at 2, byte at 3 merged over a full word
      w2 = {x3[7:0], h2[7:0], x1[7:0], b0[7:0]};
      addRow(PortCore, OpWr, 32'h0001_0020, b0, 4'hF, '0, 1);
      addRow(PortCore, OpWr, 32'h0001_0021, x1, 4'b0001, '0, 1);
      addRow(PortCore, OpWr, 32'h0001_0022, h2, 4'b0011, '0, 1);
      // Whole half word before its upper byte is overwritten
      addRow(PortCore, OpRd, 32'h0001_0022, '0, 4'hF, {16'h0, h2[15:0]}, 1);
      addRow(PortCore, OpWr, 32'h0001_0023, x3, 4'b0001, '0, 1);
      for (int k = 0; k < 4; k++) begin
         addRow(PortCore, OpRd, 32'h0001_0020 + k, '0, 4'hF, w2 >> (8 * k), 1);
      end
      // Control registers and unmapped space
      addRow(PortCore, OpWr, crAddr(CrLeds), led, 4'hF, '0, 2);
      addRow(PortLeds, OpRd, '0, '0, '0, led, 2);
      addRow(PortCore, OpRd, crAddr(CrLeds), '0, 4'hF, led, 2);
      addRow(PortCore, OpWr, crAddr(CrScratch0), s0, 4'hF, '0, 2);
      addRow(PortCore, OpWr, crAddr(CrScratch1), s1, 4'hF, '0, 2);
      addRow(PortCore, OpRd, crAddr(CrScratch0), '0, 4'hF, s0, 2);
      addRow(PortCore, OpRd, crAddr(CrScratch1), '0, 4'hF, s1, 2);
      addRow(PortCore, OpRd, crAddr(CrSwitches), '0, 4'hF, sw, 2);
      addRow(PortCore, OpRd, crAddr(CrTileId), '0, 4'hF, tData'(localTileId), 2);
      addRow(PortCore, OpWr, 32'h0005_0000, d0, 4'hF, '0, 2);
      addRow(PortCore, OpRd, 32'h0005_0000, '0, 4'hF, '0, 2);
      // Fabric writes seen by the core, fabric reads answered
      addRow(PortFabric, OpWr, 32'h0001_0040, f0, 4'hF, '0, 3);
      addRow(PortCore, OpRd, 32'h0001_0040, '0, 4'hF, f0, 3);
      addRow(PortFabric, OpWr, crAddr(CrScratch1), f1, 4'hF, '0, 3);
      addRow(PortCore, OpRd, crAddr(CrScratch1), '0, 4'hF, f1, 3);
      addRow(PortFabric, OpRd, 32'h0001_0040, '0, 4'hF, f0, 3);
      addRow(PortFabric, OpRd, crAddr(CrScratch1), '0, 4'hF, f1, 3);
      addRow(PortFabric, OpRd, 32'h0007_0010, '0, 4'hF, '0, 3);
      // FifoDepth reads back to back
      addRow(PortFabric, OpRd, 32'h0001_0010, '0, 4'hF, d0, 4);
      addRow(PortFabric, OpRd, 32'h0001_0014, '0, 4'hF, d1, 4);
      addRow(PortFabric, OpRd, 32'h0001_0040, '0, 4'hF, f0, 4);
      addRow(PortFabric, OpRd, crAddr(CrLeds), '0, 4'hF, led, 4);
      // Core wins the same-word clash
      addRow(PortClash, OpWr, 32'h0001_0050, clash, 4'hF, '0, 5);
      addRow(PortCore, OpRd, 32'h0001_0050, '0, 4'hF, clash, 5);
      addRow(PortFabric, OpRd, 32'h0001_0050, '0, 4'hF, clash, 5);

      repeat (4) @(posedge Clk);
      arstN <= 1'b1;
      credits = FifoDepth;
      @(negedge Clk);
      checkValue("fabricCredit", '0, tData'(fabricCredit));
      checkValue("fabricRspValid", '0, tData'(fabricRspValid));
      checkValue("leds", '0, leds);
      testStartErr = errCount;

      foreach (rows[i]) begin
         r = rows[i];
         lastOfTest = (i == rows.size() - 1) || (rows[i + 1].test != r.test);
         if (r.port != PortFabric) begin
            drainFabric();
         end
         if (!timedOut) begin
            case (r.port)
               PortCore:   coreAccess(r);
               PortFabric: sendFabric(r.op, r.addr, r.data, r.exp);
               PortClash:  clashWrite(r.addr, r.data);
               default: begin
                  @(negedge Clk);
                  checkValue("leds", r.exp, leds);
               end
            endcase
         end
         // Test boundary, settle the fabric
         if (!timedOut && lastOfTest) begin
            drainFabric();
         end
         if (timedOut) begin
            break;
         end
         if (lastOfTest) begin
            checkValue("fabric credits", FifoDepth, credits);
            checkValue("fabric responses", readsSent, rspCount);
            $display("Test %0d %s finished, %0d errors", r.test + 1, testNames[r.test],
                     errCount - testStartErr);
            testStartErr = errCount;
         end
      end

      $display("Summary: %0d tests, %0d checks, %0d errors", 6, checkCount, errCount);
      if (errCount == 0 && !timedOut) begin
         $display("Testbench passed");
      end else begin
         $display("Testbench failed");
      end
      $finish;
   end

endmodule

// File: tests/memTile_sva.sv
// Bound checks on the fabric credit link and the read response pipe
`timescale 1ns/100ps

module memTileSva import memTilePkg::*; #(
   parameter int FifoDepth = 4
) (
   input logic   Clk,
   input logic   arstN,
   input logic   fabricReqValid,
   input logic   fabricCredit,
   input logic   reqValidQ503H,
   input tOpcode reqOpcodeQ503H,
   input logic   fabricRspValid
);

   // Requests pushed but not yet credited back
   int   outstanding;
   logic popRd;

   assign popRd = reqValidQ503H && (reqOpcodeQ503H == OpRd);

   always_ff @(posedge Clk or negedge arstN) begin
      if (!arstN) begin
         outstanding <= 0;
      end else begin
         outstanding <= outstanding + int'(fabricReqValid) - int'(fabricCredit);
      end
   end

   // ======================================================================
   // Credit accounting
   // ======================================================================
   // No credit without an entry, never more entries than credits
   creditBound: assert property (@(posedge Clk) disable iff (!arstN)
      (outstanding >= 0) && (outstanding <= FifoDepth))
      else $error("Credits outstanding outside zero to FIFO depth");

   // Push only with room left
   noPushWhenFull: assert property (@(posedge Clk) disable iff (!arstN)
      fabricReqValid |-> (outstanding < FifoDepth))
      else $error("Fabric request pushed into a full FIFO");

   // ======================================================================
   // Response two cycles after a read pop
   // ======================================================================
   rspAfterRead: assert property (@(posedge Clk) disable iff (!arstN)
      $past(popRd, 2) |-> fabricRspValid)
      else $error("Read pop without a response two cycles later");

   rspOnlyForRead: assert property (@(posedge Clk) disable iff (!arstN)
      fabricRspValid |-> $past(popRd, 2))
      else $error("Response without a read pop two cycles earlier");

endmodule

bind memTile memTileSva #(
   .FifoDepth (FifoDepth)
) sva (
   .Clk            (Clk),
   .arstN          (arstN),
   .fabricReqValid (fabricReqValid),
   .fabricCredit   (fabricCredit),
   .reqValidQ503H  (reqValidQ503H),
   .reqOpcodeQ503H (reqOpcodeQ503H),
   .fabricRspValid (fabricRspValid)
);

// File: design/memTile.sv
// Tile memory subsystem top level
// Fabric request buffer feeding the memory wrapper
`timescale 1ns/100ps

module memTile import memTilePkg::*; #(
   parameter int FifoDepth = 4,
   parameter int DMemWords = 256
) (
   input  logic   Clk,
   input  logic   arstN,
   input  tTileId localTileId,
   // Core data port
   input  tAddr   dMemAddrQ103H,
   input  tData   dMemWrDataQ103H,
   input  tByteEn dMemByteEnQ103H,
   input  logic   dMemWrEnQ103H,
   input  logic   dMemRdEnQ103H,
   output tData   dMemRdRspQ104H,
   // Fabric requests and credits
   input  logic   fabricReqValid,
   input  tOpcode fabricReqOpcode,
   input  tAddr   fabricReqAddr,
   input  tData   fabricReqData,
   input  tTileId fabricReqRequestorId,
   output logic   fabricCredit,
   // Fabric read responses
   output logic   fabricRspValid,
   output tAddr   fabricRspAddr,
   output tData   fabricRspData,
   // Board IO
   input  tData   switches,
   output tData   leds
);

   // Buffer head toward the wrapper
   logic   reqValidQ503H;
   tOpcode reqOpcodeQ503H;
   tAddr   reqAddrQ503H;
   tData   reqDataQ503H;
   tTileId reqRequestorIdQ503H;

   fabricReqFifo #(
      .FifoDepth (FifoDepth)
   ) fabricReqFifo (
      .Clk                  (Clk),
      .arstN                (arstN),
      .fabricReqValid       (fabricReqValid),
      .fabricReqOpcode      (fabricReqOpcode),
      .fabricReqAddr        (fabricReqAddr),
      .fabricReqData        (fabricReqData),
      .fabricReqRequestorId (fabricReqRequestorId),
      .fabricCredit         (fabricCredit),
      .reqValidQ503H        (reqValidQ503H),
      .reqOpcodeQ503H       (reqOpcodeQ503H),
      .reqAddrQ503H         (reqAddrQ503H),
      .reqDataQ503H         (reqDataQ503H),
      .reqRequestorIdQ503H  (reqRequestorIdQ503H)
   );

   memWrap #(
      .DMemWords (DMemWords)
   ) memWrap (
      .Clk                 (Clk),
      .arstN               (arstN),
      .localTileId         (localTileId),
      .dMemAddrQ103H       (dMemAddrQ103H),
      .dMemWrDataQ103H     (dMemWrDataQ103H),
      .dMemByteEnQ103H     (dMemByteEnQ103H),
      .dMemWrEnQ103H       (dMemWrEnQ103H),
      .dMemRdEnQ103H       (dMemRdEnQ103H),
      .dMemRdRspQ104H      (dMemRdRspQ104H),
      .reqValidQ503H       (reqValidQ503H),
      .reqOpcodeQ503H      (reqOpcodeQ503H),
      .reqAddrQ503H        (reqAddrQ503H),
      .reqDataQ503H        (reqDataQ503H),
      .reqRequestorIdQ503H (reqRequestorIdQ503H),
      .switches            (switches),
      .leds                (leds),
      .fabricRspValid      (fabricRspValid),
      .fabricRspAddr       (fabricRspAddr),
      .fabricRspData       (fabricRspData)
   );

endmodule

// File: design/fabricReqFifo.sv
// Fabric request FIFO with credit return
// Pops the head every cycle it is non-empty, one credit per pop
`timescale 1ns/100ps

module fabricReqFifo import memTilePkg::*; #(
   parameter int FifoDepth = 4
) (
   input  logic   Clk,
   input  logic   arstN,
   // Fabric link
   input  logic   fabricReqValid,
   input  tOpcode fabricReqOpcode,
   input  tAddr   fabricReqAddr,
   input  tData   fabricReqData,
   input  tTileId fabricReqRequestorId,
   output logic   fabricCredit,
   // Head of queue toward the wrapper
   output logic   reqValidQ503H,
   output tOpcode reqOpcodeQ503H,
   output tAddr   reqAddrQ503H,
   output tData   reqDataQ503H,
   output tTileId reqRequestorIdQ503H
);

   localparam int PtrW = (FifoDepth > 1) ? $clog2(FifoDepth) : 1;
   localparam int CntW = $clog2(FifoDepth + 1);

   tOpcode opcodeMem [FifoDepth];
   tAddr   addrMem   [FifoDepth];
   tData   dataMem   [FifoDepth];
   tTileId idMem     [FifoDepth];

   logic [PtrW-1:0] wrPtr;
   logic [PtrW-1:0] rdPtr;
   logic [CntW-1:0] count;
   logic            push;
   logic            pop;

   // Circular pointer step, also for non power of two depths
   function automatic logic [PtrW-1:0] nextPtr(input logic [PtrW-1:0] ptr);
      nextPtr = (ptr == PtrW'(FifoDepth - 1)) ? '0 : ptr + 1'b1;
   endfunction

   // Sender owns the credit check, so no full gating here
   assign push = fabricReqValid;
   // Wrapper is always ready
   assign pop  = (count != '0);

   // ======================================================================
   // Pointers and occupancy
   // ======================================================================
   always_ff @(posedge Clk or negedge arstN) begin
      if (!arstN) begin
         wrPtr <= '0;
         rdPtr <= '0;
         count <= '0;
      end else begin
         if (push) begin
            wrPtr <= nextPtr(wrPtr);
         end
         if (pop) begin
            rdPtr <= nextPtr(rdPtr);
         end
         case ({push, pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

   // Entry storage
   always_ff @(posedge Clk) begin
      if (push) begin
         opcodeMem[wrPtr] <= fabricReqOpcode;
         addrMem[wrPtr]   <= fabricReqAddr;
         dataMem[wrPtr]   <= fabricReqData;
         idMem[wrPtr]     <= fabricReqRequestorId;
      end
   end

   // Head entry and its credit in the pop cycle
   assign reqValidQ503H       = pop;
   assign fabricCredit        = pop;
   assign reqOpcodeQ503H      = opcodeMem[rdPtr];
   assign reqAddrQ503H        = addrMem[rdPtr];
   assign reqDataQ503H        = dataMem[rdPtr];
   assign reqRequestorIdQ503H = idMem[rdPtr];

endmodule

// File: design/memWrap/memWrap.sv
// Memory wrapper: region decode for core and fabric accesses
// Byte-lane shifting, read muxing and the fabric read response pipe
`timescale 1ns/100ps

module memWrap import memTilePkg::*; #(
   parameter int DMemWords = 256
) (
   input  logic   Clk,
   input  logic   arstN,
   input  tTileId localTileId,
   // Core data port
   input  tAddr   dMemAddrQ103H,
   input  tData   dMemWrDataQ103H,
   input  tByteEn dMemByteEnQ103H,
   input  logic   dMemWrEnQ103H,
   input  logic   dMemRdEnQ103H,
   output tData   dMemRdRspQ104H,
   // Fabric request from the buffer
   input  logic   reqValidQ503H,
   input  tOpcode reqOpcodeQ503H,
   input  tAddr   reqAddrQ503H,
   input  tData   reqDataQ503H,
   input  tTileId reqRequestorIdQ503H,
   // Board IO
   input  tData   switches,
   output tData   leds,
   // Fabric read response
   output logic   fabricRspValid,
   output tAddr   fabricRspAddr,
   output tData   fabricRspData
);

   localparam int DMemAddrW = $clog2(DMemWords);

   // Region hit on the upper address bits
   function automatic logic inRegion(input tAddr addr, input tRegion lo, input tRegion hi);
      inRegion = (addr[RegionMsb:RegionLsb] >= lo) && (addr[RegionMsb:RegionLsb] <= hi);
   endfunction

   // ======================================================================
   // Core side, Q103H to Q104H
   // ======================================================================
   logic       coreDMemHitQ103H;
   logic       coreCrHitQ103H;
   logic [1:0] byteOffQ103H;
   logic [1:0] byteOffQ104H;
   logic       coreDMemRdQ104H;
   logic       coreCrRdQ104H;
   tData       shiftWrDataQ103H;
   tByteEn     shiftByteEnQ103H;
   tData       dMemQaQ104H;
   tData       dMemRdDataQ104H;
   tData       crQaQ104H;

   assign coreDMemHitQ103H = inRegion(dMemAddrQ103H, DMemRegionFloor, DMemRegionRoof);
   assign coreCrHitQ103H   = inRegion(dMemAddrQ103H, CrRegionFloor, CrRegionRoof);
   assign byteOffQ103H     = dMemAddrQ103H[1:0];

   // Sub-word writes move into their lanes
   assign shiftWrDataQ103H = dMemWrDataQ103H << {byteOffQ103H, 3'b000};
   assign shiftByteEnQ103H = dMemByteEnQ103H << byteOffQ103H;

   // Read selects only for real read requests
   always_ff @(posedge Clk or negedge arstN) begin
      if (!arstN) begin
         coreDMemRdQ104H <= 1'b0;
         coreCrRdQ104H   <= 1'b0;
      end else begin
         coreDMemRdQ104H <= dMemRdEnQ103H && coreDMemHitQ103H;
         coreCrRdQ104H   <= dMemRdEnQ103H && coreCrHitQ103H;
      end
   end

   always_ff @(posedge Clk) begin
      byteOffQ104H <= byteOffQ103H;
   end

   // Sub-word reads land at bit 0, upper bits zero
   assign dMemRdDataQ104H = dMemQaQ104H >> {byteOffQ104H, 3'b000};

   // CR first, then data memory, unmapped gives zero
   assign dMemRdRspQ104H = coreCrRdQ104H   ? crQaQ104H       :
                           coreDMemRdQ104H ? dMemRdDataQ104H :
                                             '0;

   // ======================================================================
   // Fabric side, Q503H to Q505H
   // ======================================================================
   logic fabDMemHitQ503H;
   logic fabCrHitQ503H;
   logic fabWrQ503H;
   logic fabRdQ503H;
   tAddr fabRspAddrQ503H;
   logic fabRdQ504H;
   logic fabDMemHitQ504H;
   logic fabCrHitQ504H;
   tAddr fabRspAddrQ504H;
   tData dMemQbQ504H;
   tData crQbQ504H;
   tData fabRspDataQ504H;

   assign fabDMemHitQ503H = inRegion(reqAddrQ503H, DMemRegionFloor, DMemRegionRoof);
   assign fabCrHitQ503H   = inRegion(reqAddrQ503H, CrRegionFloor, CrRegionRoof);
   assign fabWrQ503H      = reqValidQ503H && (reqOpcodeQ503H == OpWr);
   assign fabRdQ503H      = reqValidQ503H && (reqOpcodeQ503H == OpRd);
   // Response goes back to the requestor
   assign fabRspAddrQ503H = {reqRequestorIdQ503H, reqAddrQ503H[23:0]};

   always_ff @(posedge Clk or negedge arstN) begin
      if (!arstN) begin
         fabRdQ504H     <= 1'b0;
         fabricRspValid <= 1'b0;
      end else begin
         fabRdQ504H     <= fabRdQ503H;
         fabricRspValid <= fabRdQ504H;
      end
   end

   always_ff @(posedge Clk) begin
      fabDMemHitQ504H <= fabDMemHitQ503H;
      fabCrHitQ504H   <= fabCrHitQ503H;
      fabRspAddrQ504H <= fabRspAddrQ503H;
      fabricRspAddr   <= fabRspAddrQ504H;
      fabricRspData   <= fabRspDataQ504H;
   end

   // CR hit has the highest priority
   assign fabRspDataQ504H = fabCrHitQ504H   ? crQbQ504H   :
                            fabDMemHitQ504H ? dMemQbQ504H :
                                              '0;

   // ======================================================================
   // Storage
   // ======================================================================
   dMem #(
      .DMemWords (DMemWords)
   ) dMem (
      .Clk     (Clk),
      .addrA   (dMemAddrQ103H[DMemAddrW+1:2]),
      .dataA   (shiftWrDataQ103H),
      .byteEnA (shiftByteEnQ103H),
      .wrEnA   (dMemWrEnQ103H && coreDMemHitQ103H),
      .qA      (dMemQaQ104H),
      .addrB   (reqAddrQ503H[DMemAddrW+1:2]),
      .dataB   (reqDataQ503H),
      .wrEnB   (fabWrQ503H && fabDMemHitQ503H),
      .qB      (dMemQbQ504H)
   );

   crMem crMem (
      .Clk         (Clk),
      .arstN       (arstN),
      .addrA       (dMemAddrQ103H[15:2]),
      .dataA       (dMemWrDataQ103H),
      .wrEnA       (dMemWrEnQ103H && coreCrHitQ103H),
      .qA          (crQaQ104H),
      .addrB       (reqAddrQ503H[15:2]),
      .dataB       (reqDataQ503H),
      .wrEnB       (fabWrQ503H && fabCrHitQ503H),
      .qB          (crQbQ504H),
      .switches    (switches),
      .localTileId (localTileId),
      .leds        (leds)
   );

endmodule

// File: design/memWrap/crMem.sv
// Control register block with scratch, LED, switch and tile id registers
// Two access ports with registered reads
`timescale 1ns/100ps

module crMem import memTilePkg::*; (
   input  logic     Clk,
   input  logic     arstN,
   // Port A, core side
   input  tCrOffset addrA,
   input  tData     dataA,
   input  logic     wrEnA,
   output tData     qA,
   // Port B, fabric side
   input  tCrOffset addrB,
   input  tData     dataB,
   input  logic     wrEnB,
   output tData     qB,
   // Board IO and tile identity
   input  tData     switches,
   input  tTileId   localTileId,
   output tData     leds
);

   tData scratch0;
   tData scratch1;
   tData ledsQ;
   tData switchesQ;

   // Next value of one register, core port has priority
   function automatic tData nextReg(input tData cur, input tCrOffset off);
      if (wrEnA && (addrA == off)) begin
         nextReg = dataA;
      end else if (wrEnB && (addrB == off)) begin
         nextReg = dataB;
      end else begin
         nextReg = cur;
      end
   endfunction

   // Read decode, unknown offsets return zero
   function automatic tData readReg(input tCrOffset off);
      case (off)
         CrScratch0: readReg = scratch0;
         CrScratch1: readReg = scratch1;
         CrLeds:     readReg = ledsQ;
         CrSwitches: readReg = switchesQ;
         CrTileId:   readReg = {24'b0, localTileId};
         default:    readReg = '0;
      endcase
   endfunction

   // ======================================================================
   // Register updates
   // ======================================================================
   always_ff @(posedge Clk or negedge arstN) begin
      if (!arstN) begin
         scratch0  <= '0;
         scratch1  <= '0;
         ledsQ     <= '0;
         switchesQ <= '0;
      end else begin
         scratch0  <= nextReg(scratch0, CrScratch0);
         scratch1  <= nextReg(scratch1, CrScratch1);
         ledsQ     <= nextReg(ledsQ, CrLeds);
         // Switches sampled every cycle
         switchesQ <= switches;
      end
   end

   // Read data one cycle after the address
   always_ff @(posedge Clk) begin
      qA <= readReg(addrA);
      qB <= readReg(addrB);
   end

   assign leds = ledsQ;

endmodule

// File: design/memWrap/dMem.sv
// Dual-port data RAM, word indexed
// Byte-enabled writes on port A, full-word writes on port B
`timescale 1ns/100ps

module dMem import memTilePkg::*; #(
   parameter int DMemWords = 256
) (
   input  logic                         Clk,
   // Port A, core side
   input  logic [$clog2(DMemWords)-1:0] addrA,
   input  tData                         dataA,
   input  tByteEn                       byteEnA,
   input  logic                         wrEnA,
   output tData                         qA,
   // Port B, fabric side
   input  logic [$clog2(DMemWords)-1:0] addrB,
   input  tData                         dataB,
   input  logic                         wrEnB,
   output tData                         qB
);

   tData mem [DMemWords];

   // Writes. Port A comes last, so its enabled lanes win a same-word clash
   always_ff @(posedge Clk) begin
      if (wrEnB) begin
         mem[addrB] <= dataB;
      end
      for (int lane = 0; lane < 4; lane++) begin
         if (wrEnA && byteEnA[lane]) begin
            mem[addrA][lane*8 +: 8] <= dataA[lane*8 +: 8];
         end
      end
   end

   // Registered reads, old data on read-during-write
   always_ff @(posedge Clk) begin
      qA <= mem[addrA];
      qB <= mem[addrB];
   end

endmodule

// File: common/memTilePkg.sv
// Shared widths and typedefs for the tile memory subsystem
// Fabric opcodes, address regions and control register offsets
package memTilePkg;

   // ======================================================================
   // Plain vector types
   // ======================================================================
   // Byte address
   typedef logic [31:0] tAddr;
   // Data word
   typedef logic [31:0] tData;
   // One enable per byte lane
   typedef logic [3:0]  tByteEn;
   // Tile or requestor id
   typedef logic [7:0]  tTileId;
   // Fabric opcode
   typedef logic [1:0]  tOpcode;
   // Upper address bits used for region decode
   typedef logic [15:0] tRegion;
   // Word offset inside one 64KB region
   typedef logic [13:0] tCrOffset;

   // ======================================================================
   // Fabric opcodes
   // ======================================================================
   localparam tOpcode OpRd = 2'b00;
   localparam tOpcode OpWr = 2'b01;

   // ======================================================================
   // Address regions, compared on bits 31..16
   // ======================================================================
   localparam int RegionMsb = 31;
   localparam int RegionLsb = 16;

   // Data memory at 0x0001_0000 .. 0x0001_FFFF
   localparam tRegion DMemRegionFloor = 16'h0001;
   localparam tRegion DMemRegionRoof  = 16'h0001;
   // Control registers at 0x0002_0000 .. 0x0002_FFFF
   localparam tRegion CrRegionFloor   = 16'h0002;
   localparam tRegion CrRegionRoof    = 16'h0002;

   // ======================================================================
   // Control register word offsets
   // ======================================================================
   localparam tCrOffset CrScratch0 = 14'd0;
   localparam tCrOffset CrScratch1 = 14'd1;
   localparam tCrOffset CrLeds     = 14'd2;
   // Read only
   localparam tCrOffset CrSwitches = 14'd3;
   localparam tCrOffset CrTileId   = 14'd4;

endpackage
